/* rtl/bank_pkg.sv */
package bank_pkg;

  // ------------------------------------------------------------------------
  // bank geometry
  // ------------------------------------------------------------------------
  localparam int IQ_PTR_W   = 3;
  localparam int IQ_DEPTH   = 8;
  localparam int MSHR_NUM   = 4;
  localparam int MSHR_IDX_W = 2;
  localparam int LINE_W     = 6;
  localparam int DATA_W     = 128;

  // request field widths
  localparam int ROB_W   = 3;
  localparam int CH_W    = 2;
  localparam int SWO_W   = 7;
  localparam int WBUF_W  = 8;
  localparam int STATE_W = 2;

  // sram controller opcodes
  typedef enum logic [1:0] {
    OP_WRITE     = 2'd0,
    OP_READ      = 2'd1,
    OP_READ_FILL = 2'd2,
    OP_WRITEBACK = 2'd3
  } op_e;

  // request from the crossbar, opcode bit 0 is write and bit 1 is evict
  typedef struct packed {
    logic [ROB_W-1:0]   rob_id;
    logic [CH_W-1:0]    ch_id;
    logic [1:0]         opcode;
    logic               need_linefill;
    logic [SWO_W-1:0]   set_way_offset;
    logic [WBUF_W-1:0]  wbuffer_id;
    logic [STATE_W-1:0] state0;
    logic [STATE_W-1:0] state1;
  } bank_req_t;

  // one issue queue slot
  typedef struct packed {
    bank_req_t             req;
    logic [MSHR_IDX_W-1:0] mshr_idx;
  } iq_entry_t;

  // command toward the sram controller
  typedef struct packed {
    logic [CH_W-1:0]       ch_id;
    op_e                   opcode;
    logic [SWO_W-1:0]      set_way_offset;
    logic [WBUF_W-1:0]     wbuffer_id;
    logic [ROB_W-1:0]      rob_num;
    logic [STATE_W-1:0]    state0;
    logic [STATE_W-1:0]    state1;
    logic [MSHR_IDX_W-1:0] mshr_idx;
    logic [DATA_W-1:0]     fill0;
    logic [DATA_W-1:0]     fill1;
  } sc_cmd_t;

endpackage

/* rtl/bank_mshr.sv */
`timescale 1ns/100ps

module bank_mshr (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              req_fire_i,
  input  logic [bank_pkg::LINE_W-1:0]       req_line_i,
  input  logic                              req_need_linefill_i,
  output logic                              mshr_alloc_ok_o,
  output logic                              mshr_inflight_o,
  output logic [bank_pkg::MSHR_IDX_W-1:0]   mshr_idx_o,
  input  logic                              biu_rvalid_i,
  input  logic [bank_pkg::LINE_W-1:0]       biu_rid_i,
  input  logic [2*bank_pkg::DATA_W-1:0]     biu_rdata_i,
  input  logic                              release_i,
  input  logic [bank_pkg::MSHR_IDX_W-1:0]   release_idx_i,
  output logic [2*bank_pkg::DATA_W-1:0]     fill_data_o
);

  logic [bank_pkg::MSHR_NUM-1:0]     busy_q;
  logic [bank_pkg::MSHR_NUM-1:0]     dvalid_q;
  logic [bank_pkg::LINE_W-1:0]       line_q [bank_pkg::MSHR_NUM];
  logic [2*bank_pkg::DATA_W-1:0]     data_q [bank_pkg::MSHR_NUM];
  logic [bank_pkg::MSHR_NUM-1:0]     match;
  logic [bank_pkg::MSHR_NUM-1:0]     rid_match;
  logic [bank_pkg::MSHR_IDX_W-1:0]   match_idx;
  logic [bank_pkg::MSHR_IDX_W-1:0]   free_idx;
  logic                              free_found;
  logic                              hit;
  logic                              alloc;
  logic                              rid_now;

  // ------------------------------------------------------------------------
  // combinational lookup
  // ------------------------------------------------------------------------
  always_comb begin
    match      = '0;
    rid_match  = '0;
    match_idx  = '0;
    free_idx   = '0;
    free_found = 1'b0;
    // walk downward so the lowest slot wins
    for (int i = bank_pkg::MSHR_NUM - 1; i >= 0; i--) begin
      match[i]     = busy_q[i] && (line_q[i] == req_line_i);
      rid_match[i] = busy_q[i] && biu_rvalid_i && (line_q[i] == biu_rid_i);
      if (match[i]) begin
        match_idx = i[bank_pkg::MSHR_IDX_W-1:0];
      end
      if (!busy_q[i]) begin
        free_idx   = i[bank_pkg::MSHR_IDX_W-1:0];
        free_found = 1'b1;
      end
    end
  end

  assign hit             = |match;
  assign mshr_alloc_ok_o = hit | free_found;
  assign mshr_inflight_o = |(match & ~dvalid_q);
  assign mshr_idx_o      = hit ? match_idx : free_idx;

  assign alloc   = req_fire_i & req_need_linefill_i & ~hit;
  // a line returning while its miss is allocated lands straight in the new slot
  assign rid_now = biu_rvalid_i & (biu_rid_i == req_line_i);

  // ------------------------------------------------------------------------
  // slot state
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      busy_q   <= '0;
      dvalid_q <= '0;
    end else begin
      dvalid_q <= dvalid_q | rid_match;
      if (release_i) begin
        busy_q[release_idx_i]   <= 1'b0;
        dvalid_q[release_idx_i] <= 1'b0;
      end
      if (alloc) begin
        busy_q[free_idx]   <= 1'b1;
        dvalid_q[free_idx] <= rid_now;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < bank_pkg::MSHR_NUM; i++) begin
      if (rid_match[i]) begin
        data_q[i] <= biu_rdata_i;
      end
    end
    if (alloc) begin
      line_q[free_idx] <= req_line_i;
      if (rid_now) begin
        data_q[free_idx] <= biu_rdata_i;
      end
    end
  end

  assign fill_data_o = data_q[release_idx_i];

endmodule

/* rtl/shift_priority_arb.sv */
`timescale 1ns/100ps

module shift_priority_arb (
  input  logic [bank_pkg::IQ_DEPTH-1:0] valid_array_i,
  input  logic [bank_pkg::IQ_PTR_W-1:0] bottom_ptr_i,
  output logic [bank_pkg::IQ_PTR_W-1:0] select_ptr_o
);

  logic [2*bank_pkg::IQ_DEPTH-1:0] doubled;
  logic [bank_pkg::IQ_DEPTH-1:0]   rotated;
  logic [bank_pkg::IQ_PTR_W-1:0]   offset;

  // rotate so the bottom pointer sits at bit 0
  assign doubled = {valid_array_i, valid_array_i};
  assign rotated = doubled[bottom_ptr_i +: bank_pkg::IQ_DEPTH];

  // lowest set bit of the rotated mask
  always_comb begin
    offset = '0;
    for (int i = bank_pkg::IQ_DEPTH - 1; i >= 0; i--) begin
      if (rotated[i]) begin
        offset = i[bank_pkg::IQ_PTR_W-1:0];
      end
    end
  end

  // rotate back, wraps since depth is a power of two
  assign select_ptr_o = bottom_ptr_i + offset;

endmodule

/* rtl/bank_isu_iq.sv */
`timescale 1ns/100ps

module bank_isu_iq (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            req_valid_i,
  input  bank_pkg::bank_req_t             req_i,
  output logic                            req_ready_o,
  input  logic                            mshr_alloc_ok_i,
  input  logic                            mshr_inflight_i,
  input  logic [bank_pkg::MSHR_IDX_W-1:0] mshr_idx_i,
  input  logic                            biu_rvalid_i,
  input  logic [bank_pkg::LINE_W-1:0]     biu_rid_i,
  output logic                            issue_valid_o,
  output bank_pkg::sc_cmd_t               issue_cmd_o,
  input  logic                            issue_ready_i
);

  logic [bank_pkg::IQ_DEPTH-1:0] valid_q;
  logic [bank_pkg::IQ_DEPTH-1:0] allow_q;
  logic [bank_pkg::IQ_DEPTH-1:0] wake;
  logic [bank_pkg::IQ_DEPTH-1:0] exec_mask;
  bank_pkg::iq_entry_t           entry_q [bank_pkg::IQ_DEPTH];
  bank_pkg::iq_entry_t           sel_entry;
  bank_pkg::op_e                 sel_op;
  logic [bank_pkg::IQ_PTR_W-1:0] wr_ptr;
  logic [bank_pkg::IQ_PTR_W-1:0] bottom_ptr_q;
  logic [bank_pkg::IQ_PTR_W-1:0] select_ptr;
  logic                          full;
  logic                          wr_fire;
  logic                          issue_fire;
  logic                          rid_now;
  logic                          allow_init;

  // ------------------------------------------------------------------------
  // enqueue
  // ------------------------------------------------------------------------
  assign full        = &valid_q;
  assign req_ready_o = ~full & (~req_i.need_linefill | mshr_alloc_ok_i);
  assign wr_fire     = req_valid_i & req_ready_o;

  // lowest free slot
  always_comb begin
    wr_ptr = '0;
    for (int i = bank_pkg::IQ_DEPTH - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        wr_ptr = i[bank_pkg::IQ_PTR_W-1:0];
      end
    end
  end

  // same-line return in the acceptance cycle counts as already back
  assign rid_now    = biu_rvalid_i &
                      (req_i.set_way_offset[bank_pkg::SWO_W-1:1] == biu_rid_i);
  assign allow_init = ~(req_i.need_linefill | mshr_inflight_i) | rid_now;

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      entry_q[wr_ptr].req      <= req_i;
      entry_q[wr_ptr].mshr_idx <= mshr_idx_i;
    end
  end

  // ------------------------------------------------------------------------
  // wakeup on linefill return
  // ------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < bank_pkg::IQ_DEPTH; i++) begin
      wake[i] = valid_q[i] && biu_rvalid_i &&
                (entry_q[i].req.set_way_offset[bank_pkg::SWO_W-1:1] == biu_rid_i);
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q      <= '0;
      allow_q      <= '0;
      bottom_ptr_q <= '0;
    end else begin
      allow_q <= allow_q | wake;
      // freed slot and written slot never collide, the write goes to a free one
      if (issue_fire) begin
        valid_q[select_ptr] <= 1'b0;
        bottom_ptr_q        <= select_ptr + 1'b1;
      end
      if (wr_fire) begin
        valid_q[wr_ptr] <= 1'b1;
        allow_q[wr_ptr] <= allow_init;
      end
    end
  end

  // ------------------------------------------------------------------------
  // select and dequeue
  // ------------------------------------------------------------------------
  assign exec_mask = valid_q & allow_q;

  shift_priority_arb u_arb (
    .valid_array_i (exec_mask),
    .bottom_ptr_i  (bottom_ptr_q),
    .select_ptr_o  (select_ptr)
  );

  assign issue_valid_o = |exec_mask;
  // dequeue only when the output stage takes the command
  assign issue_fire    = issue_valid_o & issue_ready_i;
  assign sel_entry     = entry_q[select_ptr];

  // evict over write over linefill over plain read
  always_comb begin
    if (sel_entry.req.opcode[1]) begin
      sel_op = bank_pkg::OP_WRITEBACK;
    end else if (sel_entry.req.opcode[0]) begin
      sel_op = bank_pkg::OP_WRITE;
    end else if (sel_entry.req.need_linefill) begin
      sel_op = bank_pkg::OP_READ_FILL;
    end else begin
      sel_op = bank_pkg::OP_READ;
    end
  end

  always_comb begin
    issue_cmd_o                = '0;
    issue_cmd_o.ch_id          = sel_entry.req.ch_id;
    issue_cmd_o.opcode         = sel_op;
    issue_cmd_o.set_way_offset = sel_entry.req.set_way_offset;
    issue_cmd_o.wbuffer_id     = sel_entry.req.wbuffer_id;
    issue_cmd_o.rob_num        = sel_entry.req.rob_id;
    issue_cmd_o.state0         = sel_entry.req.state0;
    issue_cmd_o.state1         = sel_entry.req.state1;
    issue_cmd_o.mshr_idx       = sel_entry.mshr_idx;
    // fill data is attached by the output stage
  end

endmodule

/* rtl/bank_sc_stage.sv */
`timescale 1ns/100ps

module bank_sc_stage (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            issue_valid_i,
  input  bank_pkg::sc_cmd_t               issue_cmd_i,
  output logic                            issue_ready_o,
  input  logic [2*bank_pkg::DATA_W-1:0]   fill_data_i,
  output logic                            release_o,
  output logic [bank_pkg::MSHR_IDX_W-1:0] release_idx_o,
  output logic                            sc_valid_o,
  output bank_pkg::sc_cmd_t               sc_cmd_o,
  input  logic                            sc_ready_i
);

  logic              valid_q;
  bank_pkg::sc_cmd_t cmd_q;
  logic              load;
  logic              is_fill;

  // take a new command when empty or when the current one leaves
  assign issue_ready_o = ~valid_q | sc_ready_i;
  assign load          = issue_valid_i & issue_ready_o;
  assign is_fill       = issue_cmd_i.opcode == bank_pkg::OP_READ_FILL;

  // ------------------------------------------------------------------------
  // mshr slot hand-back
  // ------------------------------------------------------------------------
  assign release_o     = load & is_fill;
  assign release_idx_o = issue_cmd_i.mshr_idx;

  // ------------------------------------------------------------------------
  // output register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (sc_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      cmd_q <= issue_cmd_i;
      // low half is offset 0
      if (is_fill) begin
        cmd_q.fill0 <= fill_data_i[bank_pkg::DATA_W-1:0];
        cmd_q.fill1 <= fill_data_i[2*bank_pkg::DATA_W-1:bank_pkg::DATA_W];
      end
    end
  end

  assign sc_valid_o = valid_q;
  assign sc_cmd_o   = cmd_q;

endmodule

/* rtl/bank_isu_top.sv */
`timescale 1ns/100ps

module bank_isu_top (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          req_valid_i,
  input  bank_pkg::bank_req_t           req_i,
  output logic                          req_ready_o,
  input  logic                          biu_rvalid_i,
  input  logic [bank_pkg::LINE_W-1:0]   biu_rid_i,
  input  logic [2*bank_pkg::DATA_W-1:0] biu_rdata_i,
  output logic                          sc_valid_o,
  output bank_pkg::sc_cmd_t             sc_cmd_o,
  input  logic                          sc_ready_i
);

  logic                            mshr_alloc_ok;
  logic                            mshr_inflight;
  logic [bank_pkg::MSHR_IDX_W-1:0] mshr_idx;
  logic                            mshr_release;
  logic [bank_pkg::MSHR_IDX_W-1:0] release_idx;
  logic [2*bank_pkg::DATA_W-1:0]   fill_data;
  logic                            issue_valid;
  logic                            issue_ready;
  bank_pkg::sc_cmd_t               issue_cmd;

  bank_mshr u_mshr (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .req_fire_i          (req_valid_i & req_ready_o),
    .req_line_i          (req_i.set_way_offset[bank_pkg::SWO_W-1:1]),
    .req_need_linefill_i (req_i.need_linefill),
    .mshr_alloc_ok_o     (mshr_alloc_ok),
    .mshr_inflight_o     (mshr_inflight),
    .mshr_idx_o          (mshr_idx),
    .biu_rvalid_i        (biu_rvalid_i),
    .biu_rid_i           (biu_rid_i),
    .biu_rdata_i         (biu_rdata_i),
    .release_i           (mshr_release),
    .release_idx_i       (release_idx),
    .fill_data_o         (fill_data)
  );

  bank_isu_iq u_iq (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .mshr_alloc_ok_i (mshr_alloc_ok),
    .mshr_inflight_i (mshr_inflight),
    .mshr_idx_i      (mshr_idx),
    .biu_rvalid_i    (biu_rvalid_i),
    .biu_rid_i       (biu_rid_i),
    .issue_valid_o   (issue_valid),
    .issue_cmd_o     (issue_cmd),
    .issue_ready_i   (issue_ready)
  );

  bank_sc_stage u_sc_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid),
    .issue_cmd_i   (issue_cmd),
    .issue_ready_o (issue_ready),
    .fill_data_i   (fill_data),
    .release_o     (mshr_release),
    .release_idx_o (release_idx),
    .sc_valid_o    (sc_valid_o),
    .sc_cmd_o      (sc_cmd_o),
    .sc_ready_i    (sc_ready_i)
  );

endmodule

/* bench/bank_isu_assert.sv */
`timescale 1ns/100ps

module bank_isu_assert (
  input logic                          clk_i,
  input logic                          rst_i,
  input logic                          req_valid_i,
  input logic                          req_ready_o,
  input logic                          sc_valid_o,
  input bank_pkg::sc_cmd_t             sc_cmd_o,
  input logic                          sc_ready_i,
  input logic [bank_pkg::IQ_DEPTH-1:0] iq_valid_i,
  input logic [bank_pkg::MSHR_NUM-1:0] mshr_busy_i
);

  // stalled command holds
  stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    sc_valid_o && !sc_ready_i |=> sc_valid_o && $stable(sc_cmd_o))
    else $error("sc command changed while stalled");

  // a refused request meets a full queue or a full mshr
  refuse_cause: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i && !req_ready_o |-> (&iq_valid_i) || (&mshr_busy_i))
    else $error("request refused with room in queue and mshr");

  reset_idle: assert property (@(posedge clk_i)
    rst_i || $past(rst_i) |-> !sc_valid_o)
    else $error("sc_valid_o high around reset");

endmodule

bind bank_isu_top bank_isu_assert u_assert (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .req_valid_i (req_valid_i),
  .req_ready_o (req_ready_o),
  .sc_valid_o  (sc_valid_o),
  .sc_cmd_o    (sc_cmd_o),
  .sc_ready_i  (sc_ready_i),
  .iq_valid_i  (u_iq.valid_q),
  .mshr_busy_i (u_mshr.busy_q)
);

/* bench/bank_isu_tb.sv */
`timescale 1ns/100ps

module bank_isu_tb;

  // a table row holds a request and/or a line return plus what to expect
  typedef struct packed {
    logic                req_en;
    bank_pkg::bank_req_t req;
    logic [3:0]          gap;
    logic                ret_en;
    logic [5:0]          ret_line;
    logic [1:0]          rdy_mode;
    logic [1:0]          chk;
    bank_pkg::op_e       exp_op;
  } row_t;

  // rdy_mode 0 keeps ready high, 1 holds it low and 2 randomizes it
  // chk 1 checks hit latency, 2 a full queue after accept, 3 a refusal in the first cycle

  logic                          clk_i = 1'b0;
  logic                          rst_i = 1'b1;
  logic                          req_valid_i;
  bank_pkg::bank_req_t           req_i;
  logic                          req_ready_o;
  logic                          biu_rvalid_i;
  logic [bank_pkg::LINE_W-1:0]   biu_rid_i;
  logic [2*bank_pkg::DATA_W-1:0] biu_rdata_i;
  logic                          sc_valid_o;
  bank_pkg::sc_cmd_t             sc_cmd_o;
  logic                          sc_ready_i;

  row_t              rows[$];
  row_t              cur = '0;
  bank_pkg::sc_cmd_t exp_cmd [8];
  int                accept_cyc [8];
  logic [7:0]        exp_valid = '0;
  logic [7:0]        need_ret = '0;
  logic [7:0]        chk_lat = '0;
  logic [63:0]       line_out = '0;
  logic [31:0]       lfsr = 32'hbe9e_c29c;
  logic [1:0]        rdy_mode = 2'd0;
  int                cyc = 0;
  int                errors = 0;
  int                timeouts = 0;

  bank_isu_top DUT (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // every word of a returned line depends on the line index
  function automatic logic [255:0] line_data(input logic [5:0] line);
    logic [255:0] d;
    for (int j = 0; j < 8; j++) begin
      d[j*32 +: 32] = {line, 3'(j), 23'h5a5a5} ^ (32'h9e37_79b1 * (line + 1));
    end
    return d;
  endfunction

  function automatic bank_pkg::op_e expect_op(input logic [1:0] opc);
    if (opc[1]) return bank_pkg::OP_WRITEBACK;
    if (opc[0]) return bank_pkg::OP_WRITE;
    return bank_pkg::OP_READ;
  endfunction

  task automatic check(input string what, input logic [283:0] got, input logic [283:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic end_run();
    $display("errors %0d, timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    timeouts++;
    $display("timeout while waiting for %s", what);
  endtask

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic add_row(input int rob, input logic [1:0] opc, input logic nlf,
                         input logic [5:0] line, input int gap, input logic ret,
                         input logic [5:0] rl, input logic [1:0] mode,
                         input logic [1:0] chk, input bank_pkg::op_e exp);
    row_t rw;
    rw = '0;
    rw.req_en               = rob >= 0;
    rw.req.rob_id           = rob[2:0];
    rw.req.ch_id            = rand_bits(2);
    rw.req.opcode           = opc;
    rw.req.need_linefill    = nlf;
    rw.req.set_way_offset   = {line, rand_bits(1) != 0};
    rw.req.wbuffer_id       = rand_bits(8);
    rw.req.state0           = rand_bits(2);
    rw.req.state1           = rand_bits(2);
    rw.gap                  = gap;
    rw.ret_en               = ret;
    rw.ret_line             = rl;
    rw.rdy_mode             = mode;
    rw.chk                  = chk;
    rw.exp_op               = exp;
    rows.push_back(rw);
  endtask

  task automatic build_table();
    logic [1:0] opc;
    // isolated hits
    add_row(0, 2'b00, 0, 1, 1, 0, 0, 0, 1, bank_pkg::OP_READ);
    add_row(1, 2'b01, 0, 2, 3, 0, 0, 0, 1, bank_pkg::OP_WRITE);
    add_row(2, 2'b10, 0, 3, 3, 0, 0, 0, 1, bank_pkg::OP_WRITEBACK);
    add_row(3, 2'b11, 0, 4, 3, 0, 0, 0, 1, bank_pkg::OP_WRITEBACK);
    // miss, hit behind it, other line passing
    add_row(4, 2'b00, 1, 10, 3, 0, 0, 0, 0, bank_pkg::OP_READ_FILL);
    add_row(5, 2'b00, 0, 10, 0, 0, 0, 0, 0, bank_pkg::OP_READ);
    add_row(6, 2'b00, 0, 11, 0, 0, 0, 0, 1, bank_pkg::OP_READ);
    add_row(-1, 2'b00, 0, 0, 4, 1, 10, 0, 0, bank_pkg::OP_READ);
    // fill the queue while stalled
    add_row(7, 2'b00, 1, 12, 6, 0, 0, 1, 0, bank_pkg::OP_READ_FILL);
    for (int r = 0; r < 7; r++) begin
      add_row(r, 2'b00, 0, 12, 0, 0, 0, 1, (r == 6) ? 2 : 0, bank_pkg::OP_READ);
    end
    add_row(-1, 2'b00, 0, 0, 2, 1, 12, 1, 0, bank_pkg::OP_READ);
    // five misses against four mshr slots
    for (int r = 0; r < 4; r++) begin
      add_row(r, 2'b00, 1, 20 + r, (r == 0) ? 8 : 0, 0, 0, 0, 0, bank_pkg::OP_READ_FILL);
    end
    add_row(4, 2'b00, 1, 24, 0, 1, 20, 0, 3, bank_pkg::OP_READ_FILL);
    for (int r = 1; r < 5; r++) begin
      add_row(-1, 2'b00, 0, 0, 1, 1, 20 + r, 0, 0, bank_pkg::OP_READ);
    end
    // long run with random back-pressure
    for (int i = 0; i < 40; i++) begin
      if (i % 5 == 4) begin
        add_row(i % 8, 2'b00, 1, 6'(32 + i / 5), 0, 0, 0, 2, 0, bank_pkg::OP_READ_FILL);
        add_row(-1, 2'b00, 0, 0, 1, 1, 6'(32 + i / 5), 2, 0, bank_pkg::OP_READ);
      end else begin
        opc = rand_bits(2);
        add_row(i % 8, opc, 0, rand_bits(5), rand_bits(2), 0, 0, 2, 0, expect_op(opc));
      end
    end
  endtask

  task automatic apply_row(input row_t rw);
    int n;
    repeat (rw.gap) step();
    // the row's ready mode also covers the wait for its rob id
    rdy_mode = rw.rdy_mode;
    n = 0;
    while (rw.req_en && exp_valid[rw.req.rob_id]) begin
      step();
      n++;
      if (n > 500) begin
        timed_out("a free rob id");
        return;
      end
    end
    cur          = rw;
    req_valid_i  = rw.req_en;
    req_i        = rw.req;
    biu_rvalid_i = rw.ret_en;
    biu_rid_i    = rw.ret_line;
    biu_rdata_i  = line_data(rw.ret_line);
    n = 0;
    forever begin
      @(negedge clk_i);
      if (rw.chk == 3 && n == 0) check("ready with mshr full", req_ready_o, 1'b0);
      if (!rw.req_en || req_ready_o) break;
      n++;
      if (n > 500) begin
        timed_out("request acceptance");
        return;
      end
      step();
      biu_rvalid_i = 1'b0;
    end
    step();
    req_valid_i  = 1'b0;
    biu_rvalid_i = 1'b0;
    if (rw.chk == 2) begin
      @(negedge clk_i);
      check("ready with full queue", req_ready_o, 1'b0);
    end
  endtask

  // ---------------------------------------------------------------------------
  // back-pressure and scoreboard
  // ---------------------------------------------------------------------------
  always @(posedge clk_i) begin : drive_ready
    logic [1:0] mode;
    mode = rdy_mode;
    #1;
    if (mode == 2'd0) sc_ready_i = 1'b1;
    else if (mode == 2'd1) sc_ready_i = 1'b0;
    else sc_ready_i = rand_bits(1) != 0;
  end

  always @(negedge clk_i) begin : track
    int                r;
    logic [5:0]        ln;
    bank_pkg::sc_cmd_t got;
    bank_pkg::sc_cmd_t e;
    if (!rst_i) begin
      if (sc_valid_o && sc_ready_i) begin
        got          = sc_cmd_o;
        got.mshr_idx = '0;
        r            = got.rob_num;
        if (!exp_valid[r]) begin
          errors++;
          $display("unexpected command for rob %0d at %0t ns", r, $time);
        end else begin
          if (need_ret[r]) begin
            errors++;
            $display("rob %0d issued before its line returned", r);
          end
          check("command", got, exp_cmd[r]);
          if (chk_lat[r]) check("hit latency", cyc - accept_cyc[r], 2);
          exp_valid[r] = 1'b0;
        end
      end
      // a return in the accept cycle counts for the new request too
      if (biu_rvalid_i) begin
        for (int i = 0; i < 8; i++) begin
          if (exp_cmd[i].set_way_offset[6:1] == biu_rid_i) need_ret[i] = 1'b0;
        end
        line_out[biu_rid_i] = 1'b0;
      end
      if (req_valid_i && req_ready_o) begin
        r                = req_i.rob_id;
        ln               = req_i.set_way_offset[6:1];
        e                = '0;
        e.ch_id          = req_i.ch_id;
        e.opcode         = cur.exp_op;
        e.set_way_offset = req_i.set_way_offset;
        e.wbuffer_id     = req_i.wbuffer_id;
        e.rob_num        = req_i.rob_id;
        e.state0         = req_i.state0;
        e.state1         = req_i.state1;
        if (cur.exp_op == bank_pkg::OP_READ_FILL) {e.fill1, e.fill0} = line_data(ln);
        exp_cmd[r]    = e;
        need_ret[r]   = (req_i.need_linefill || line_out[ln]) &&
                        !(biu_rvalid_i && biu_rid_i == ln);
        if (need_ret[r]) line_out[ln] = 1'b1;
        accept_cyc[r] = cyc;
        chk_lat[r]    = cur.chk == 2'd1;
        exp_valid[r]  = 1'b1;
      end
    end
  end

  initial begin : main
    int n;
    req_valid_i  = 1'b0;
    req_i        = '0;
    biu_rvalid_i = 1'b0;
    biu_rid_i    = '0;
    biu_rdata_i  = '0;
    sc_ready_i   = 1'b1;
    build_table();
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    foreach (rows[i]) begin
      if (timeouts == 0) apply_row(rows[i]);
    end
    rdy_mode = 2'd0;
    n = 0;
    while (exp_valid != '0 && timeouts == 0) begin
      step();
      n++;
      if (n > 1000) timed_out("outstanding commands");
    end
    end_run();
  end

endmodule

/* vlog.f */
rtl/bank_pkg.sv
rtl/bank_mshr.sv
rtl/shift_priority_arb.sv
rtl/bank_isu_iq.sv
rtl/bank_sc_stage.sv
rtl/bank_isu_top.sv
bench/bank_isu_assert.sv
bench/bank_isu_tb.sv
